//--- hw/axi_sram_pkg.sv
`default_nettype none

package axi_sram_pkg;

    // ==============================
    // Bus widths
    // ==============================
    localparam int ADDR_BITS = 32;
    localparam int DATA_BITS = 32;
    localparam int ID_BITS   = 4;
    localparam int LEN_BITS  = 8;

    // ==============================
    // Memory geometry
    // ==============================
    // 1024 words of 4 bytes
    localparam int MEM_ADDR_BITS = 10;
    localparam int MEM_WORDS     = 1 << MEM_ADDR_BITS;
    // Byte offset inside a word is dropped
    localparam int WORD_LSB      = 2;

    // Read response queue
    localparam int RQ_DEPTH    = 4;
    localparam int RQ_PTR_BITS = $clog2(RQ_DEPTH);
    // One extra bit so a full queue can be told from an empty one
    localparam int RQ_CNT_BITS = RQ_PTR_BITS + 1;

    // Only OKAY is ever returned
    localparam logic [1:0] RESP_OKAY = 2'b00;

    // Burst controller states, read side never uses ST_RESP
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DATA,
        ST_RESP
    } burst_state_e;

    typedef logic [MEM_ADDR_BITS-1:0] mem_addr_t;
    typedef logic [DATA_BITS-1:0]     data_t;
    typedef logic [ID_BITS-1:0]       id_t;

endpackage

`default_nettype wire

//--- hw/axi_sram_top.sv
`timescale 1ns/1ps
`default_nettype none

module axi_sram_top (
    input  logic                                ACLK,
    input  logic                                ARESETn,
    // AW channel
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [axi_sram_pkg::ADDR_BITS-1:0]  awaddr,
    input  axi_sram_pkg::id_t                   awid,
    input  logic [axi_sram_pkg::LEN_BITS-1:0]   awlen,
    // W channel
    input  logic                                wvalid,
    output logic                                wready,
    input  axi_sram_pkg::data_t                 wdata,
    input  logic                                wlast,
    // B channel
    output logic                                bvalid,
    input  logic                                bready,
    output axi_sram_pkg::id_t                   bid,
    output logic [1:0]                          bresp,
    // AR channel
    input  logic                                arvalid,
    output logic                                arready,
    input  logic [axi_sram_pkg::ADDR_BITS-1:0]  araddr,
    input  axi_sram_pkg::id_t                   arid,
    input  logic [axi_sram_pkg::LEN_BITS-1:0]   arlen,
    // R channel
    output logic                                rvalid,
    input  logic                                rready,
    output axi_sram_pkg::data_t                 rdata,
    output axi_sram_pkg::id_t                   rid,
    output logic [1:0]                          rresp,
    output logic                                rlast
);

    // ==============================
    // Internal links
    // ==============================
    wr_req_if  wr_req ();
    rd_req_if  rd_req ();
    rd_beat_if rd_beat ();

    // No error cases, every response is OKAY
    assign bresp = axi_sram_pkg::RESP_OKAY;
    assign rresp = axi_sram_pkg::RESP_OKAY;

    // Write path, AW/W/B
    write_burst_ctrl u_wr_ctrl (
        .ACLK    (ACLK),
        .ARESETn (ARESETn),
        .awvalid (awvalid),
        .awaddr  (awaddr),
        .awid    (awid),
        .awlen   (awlen),
        .awready (awready),
        .wvalid  (wvalid),
        .wdata   (wdata),
        .wlast   (wlast),
        .wready  (wready),
        .bready  (bready),
        .bvalid  (bvalid),
        .bid     (bid),
        .wr      (wr_req.ctrl)
    );

    // Read address path
    read_burst_ctrl u_rd_ctrl (
        .ACLK    (ACLK),
        .ARESETn (ARESETn),
        .arvalid (arvalid),
        .araddr  (araddr),
        .arid    (arid),
        .arlen   (arlen),
        .arready (arready),
        .rd      (rd_req.ctrl)
    );

    // Shared array
    sram_bank u_bank (
        .ACLK    (ACLK),
        .ARESETn (ARESETn),
        .wr      (wr_req.bank),
        .rd      (rd_req.bank),
        .beat    (rd_beat.bank)
    );

    // R channel buffer
    read_resp_queue u_rq (
        .ACLK    (ACLK),
        .ARESETn (ARESETn),
        .beat    (rd_beat.queue),
        .rvalid  (rvalid),
        .rdata   (rdata),
        .rid     (rid),
        .rlast   (rlast),
        .rready  (rready)
    );

endmodule

`default_nettype wire

//--- hw/mem_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// Write request from write controller into the bank
interface wr_req_if;
    logic                   valid;
    logic                   ready;
    axi_sram_pkg::mem_addr_t addr;
    axi_sram_pkg::data_t     data;

    modport ctrl (output valid, output addr, output data, input ready);
    modport bank (input valid, input addr, input data, output ready);
endinterface

// Read request from read controller into the bank
interface rd_req_if;
    logic                    valid;
    logic                    ready;
    axi_sram_pkg::mem_addr_t addr;
    axi_sram_pkg::id_t       id;
    // Marks the final request of a burst
    logic                    last;

    modport ctrl (output valid, output addr, output id, output last, input ready);
    modport bank (input valid, input addr, input id, input last, output ready);
endinterface

// Read beat from the bank into the response queue
interface rd_beat_if;
    // No ready here, the queue must always take a beat
    logic                valid;
    axi_sram_pkg::data_t data;
    axi_sram_pkg::id_t   id;
    logic                last;
    // Queue can take one more beat beyond the one in flight
    logic                room;

    modport bank (output valid, output data, output id, output last, input room);
    modport queue (input valid, input data, input id, input last, output room);
endinterface

`default_nettype wire

//--- hw/read_burst_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module read_burst_ctrl (
    input  logic                                ACLK,
    input  logic                                ARESETn,
    // AR channel
    input  logic                                arvalid,
    input  logic [axi_sram_pkg::ADDR_BITS-1:0]  araddr,
    input  axi_sram_pkg::id_t                   arid,
    input  logic [axi_sram_pkg::LEN_BITS-1:0]   arlen,
    output logic                                arready,
    // Request port into the bank
    rd_req_if.ctrl                              rd
);

    axi_sram_pkg::burst_state_e          state_q;
    axi_sram_pkg::mem_addr_t             addr_q;
    axi_sram_pkg::id_t                   id_q;
    // Requests still to go after the current one
    logic [axi_sram_pkg::LEN_BITS-1:0]   remain_q;

    logic ar_fire;
    logic rd_fire;

    assign arready = (state_q == axi_sram_pkg::ST_IDLE);
    assign ar_fire = arvalid && arready;

    // One request per cycle while the burst is open
    assign rd.valid = (state_q == axi_sram_pkg::ST_DATA);
    assign rd.addr  = addr_q;
    assign rd.id    = id_q;
    assign rd.last  = (remain_q == '0);
    assign rd_fire  = rd.valid && rd.ready;

    // ==============================
    // FSM
    // ==============================
    // Back to idle as soon as the final request is taken,
    // its beats may still sit in the response queue
    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state_q <= axi_sram_pkg::ST_IDLE;
        end else if (ar_fire) begin
            state_q <= axi_sram_pkg::ST_DATA;
        end else if (rd_fire && rd.last) begin
            state_q <= axi_sram_pkg::ST_IDLE;
        end
    end

    // Burst address and count
    always_ff @(posedge ACLK) begin
        if (ar_fire) begin
            addr_q   <= araddr[axi_sram_pkg::WORD_LSB +: axi_sram_pkg::MEM_ADDR_BITS];
            id_q     <= arid;
            remain_q <= arlen;
        end else if (rd_fire) begin
            // Wraps at the top of the array
            addr_q   <= addr_q + 1'b1;
            remain_q <= remain_q - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hw/read_resp_queue.sv
`timescale 1ns/1ps
`default_nettype none

module read_resp_queue (
    input  logic                 ACLK,
    input  logic                 ARESETn,
    rd_beat_if.queue             beat,
    // R channel
    output logic                 rvalid,
    output axi_sram_pkg::data_t  rdata,
    output axi_sram_pkg::id_t    rid,
    output logic                 rlast,
    input  logic                 rready
);

    // Entry storage, split by field
    axi_sram_pkg::data_t data_mem [axi_sram_pkg::RQ_DEPTH];
    axi_sram_pkg::id_t   id_mem   [axi_sram_pkg::RQ_DEPTH];
    logic                last_mem [axi_sram_pkg::RQ_DEPTH];

    logic [axi_sram_pkg::RQ_PTR_BITS-1:0] wr_ptr_q;
    logic [axi_sram_pkg::RQ_PTR_BITS-1:0] rd_ptr_q;
    logic [axi_sram_pkg::RQ_CNT_BITS-1:0] count_q;
    // Occupancy once the beat in flight lands
    logic [axi_sram_pkg::RQ_CNT_BITS-1:0] count_fill;

    logic push;
    logic pop;

    // Bank beats are never refused
    assign push = beat.valid;
    assign pop  = rvalid && rready;

    // ==============================
    // Flow control
    // ==============================
    // A read granted now lands one cycle later, so the beat
    // already on the wire must be counted too
    assign count_fill = count_q + axi_sram_pkg::RQ_CNT_BITS'(beat.valid);
    assign beat.room  = (count_fill < axi_sram_pkg::RQ_CNT_BITS'(axi_sram_pkg::RQ_DEPTH));

    // Head entry drives R
    assign rvalid = (count_q != '0);
    assign rdata  = data_mem[rd_ptr_q];
    assign rid    = id_mem[rd_ptr_q];
    assign rlast  = last_mem[rd_ptr_q];

    // Pointers and occupancy
    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // Both at once leave the count alone
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Entry write, visible on R next cycle
    always_ff @(posedge ACLK) begin
        if (push) begin
            data_mem[wr_ptr_q] <= beat.data;
            id_mem[wr_ptr_q]   <= beat.id;
            last_mem[wr_ptr_q] <= beat.last;
        end
    end

endmodule

`default_nettype wire

//--- hw/sram_bank.sv
`timescale 1ns/1ps
`default_nettype none

module sram_bank (
    input  logic      ACLK,
    input  logic      ARESETn,
    wr_req_if.bank    wr,
    rd_req_if.bank    rd,
    rd_beat_if.bank   beat
);

    // Single port word array
    axi_sram_pkg::data_t mem [axi_sram_pkg::MEM_WORDS];

    axi_sram_pkg::data_t rd_data_q;
    axi_sram_pkg::id_t   rd_id_q;
    logic                rd_last_q;
    logic                beat_valid_q;

    logic rd_grant;
    logic wr_grant;

    // ==============================
    // Arbitration
    // ==============================
    // Read first, but only when the queue can hold the result
    assign rd.ready = beat.room;
    assign rd_grant = rd.valid && beat.room;

    // Write gets the port in every cycle with no read
    assign wr.ready = !rd_grant;
    assign wr_grant = wr.valid && wr.ready;

    // Array access
    always_ff @(posedge ACLK) begin
        if (wr_grant) begin
            mem[wr.addr] <= wr.data;
        end
        if (rd_grant) begin
            rd_data_q <= mem[rd.addr];
            rd_id_q   <= rd.id;
            rd_last_q <= rd.last;
        end
    end

    // Beat valid one cycle after a granted read
    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            beat_valid_q <= 1'b0;
        end else begin
            beat_valid_q <= rd_grant;
        end
    end

    assign beat.valid = beat_valid_q;
    assign beat.data  = rd_data_q;
    assign beat.id    = rd_id_q;
    assign beat.last  = rd_last_q;

endmodule

`default_nettype wire

//--- hw/write_burst_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module write_burst_ctrl (
    input  logic                                   ACLK,
    input  logic                                   ARESETn,
    // AW channel
    input  logic                                   awvalid,
    input  logic [axi_sram_pkg::ADDR_BITS-1:0]     awaddr,
    input  axi_sram_pkg::id_t                      awid,
    input  logic [axi_sram_pkg::LEN_BITS-1:0]      awlen,
    output logic                                   awready,
    // W channel
    input  logic                                   wvalid,
    input  axi_sram_pkg::data_t                    wdata,
    input  logic                                   wlast,
    output logic                                   wready,
    // B channel
    input  logic                                   bready,
    output logic                                   bvalid,
    output axi_sram_pkg::id_t                      bid,
    // Request port into the bank
    wr_req_if.ctrl                                 wr
);

    axi_sram_pkg::burst_state_e state_q;
    axi_sram_pkg::burst_state_e state_d;
    axi_sram_pkg::mem_addr_t    addr_q;
    axi_sram_pkg::id_t          id_q;

    logic aw_fire;
    logic w_fire;

    // ==============================
    // Handshakes
    // ==============================
    // Only one burst at a time, AW taken in idle
    assign awready = (state_q == axi_sram_pkg::ST_IDLE);
    assign aw_fire = awvalid && awready;

    // W beat goes straight to the bank, so wready is the bank grant
    assign wready  = (state_q == axi_sram_pkg::ST_DATA) && wr.ready;
    assign w_fire  = wvalid && wready;

    // Write request
    assign wr.valid = (state_q == axi_sram_pkg::ST_DATA) && wvalid;
    assign wr.addr  = addr_q;
    assign wr.data  = wdata;

    // Response held in ST_RESP until bready
    assign bvalid = (state_q == axi_sram_pkg::ST_RESP);
    assign bid    = id_q;

    // ==============================
    // FSM
    // ==============================
    always_comb begin
        state_d = state_q;
        case (state_q)
            axi_sram_pkg::ST_IDLE: begin
                if (aw_fire) begin
                    state_d = axi_sram_pkg::ST_DATA;
                end
            end
            axi_sram_pkg::ST_DATA: begin
                // awlen is not counted, WLAST alone closes the burst
                if (w_fire && wlast) begin
                    state_d = axi_sram_pkg::ST_RESP;
                end
            end
            axi_sram_pkg::ST_RESP: begin
                if (bready) begin
                    state_d = axi_sram_pkg::ST_IDLE;
                end
            end
            default: state_d = axi_sram_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state_q <= axi_sram_pkg::ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Word address and ID of the current burst
    always_ff @(posedge ACLK) begin
        if (aw_fire) begin
            // Upper address bits fall off, so the array wraps
            addr_q <= awaddr[axi_sram_pkg::WORD_LSB +: axi_sram_pkg::MEM_ADDR_BITS];
            id_q   <= awid;
        end else if (w_fire) begin
            addr_q <= addr_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator, verdict taken from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_axi_sram -Mdir obj_dir

./obj_dir/Vtb_axi_sram | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
grep -q "TEST RESULT: PASS" sim.log

//--- sim.f
hw/axi_sram_pkg.sv
hw/mem_ifs.sv
hw/write_burst_ctrl.sv
hw/read_burst_ctrl.sv
hw/sram_bank.sv
hw/read_resp_queue.sv
hw/axi_sram_top.sv
sim/tb_axi_sram.sv

//--- sim/tb_axi_sram.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_sram;

    localparam int TIMEOUT = 200;
    localparam logic [15:0] SEED = 16'd18948;

    typedef struct packed {
        axi_sram_pkg::data_t data;
        axi_sram_pkg::id_t   id;
        logic                last;
    } beat_t;

    logic ACLK;
    logic ARESETn;

    // AXI signals seen from the master side
    logic                awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    logic [31:0]         awaddr, araddr;
    axi_sram_pkg::id_t   awid, bid, arid, rid;
    logic [7:0]          awlen, arlen;
    axi_sram_pkg::data_t wdata, rdata;
    logic [1:0]          bresp, rresp;
    logic                arvalid, arready, rvalid, rready, rlast;

    // ==============================
    // Checker state
    // ==============================
    axi_sram_pkg::data_t      ref_mem [axi_sram_pkg::MEM_WORDS];
    beat_t                    exp_q [$];
    beat_t                    mon_beat;
    int                       mon_i;
    axi_sram_pkg::mem_addr_t  wr_word;
    axi_sram_pkg::mem_addr_t  rd_word;
    axi_sram_pkg::id_t        exp_bid;
    logic                     b_pending;
    // Head of the expected read queue, refreshed on every rising edge
    int                       exp_cnt;
    axi_sram_pkg::data_t      exp_data;
    axi_sram_pkg::id_t        exp_id;
    logic                     exp_last;

    logic        reset_chk;
    string       test_name;
    int          data_errs, proto_errs, timeouts;
    int          lens [3];
    int          k;
    logic [15:0] lfsr_q = SEED;

    axi_sram_top uut (.*);

    initial begin
        ACLK = 1'b0;
        forever #2 ACLK = ~ACLK;
    end

    // Galois LFSR, taps 16 14 13 11, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    task automatic report_timeout(input string what);
        timeouts++;
        $display("Timeout while waiting for %s in test %s", what, test_name);
    endtask

    // ==============================
    // Master tasks
    // ==============================
    // All tasks start and end just after a rising edge

    // AW handshake, then every W beat with optional random gaps
    task automatic write_burst(input logic [31:0] addr, input int id, input int len,
                               input bit stall);
        int beat_no;
        int gap;
        int n;
        awvalid <= 1'b1;
        awaddr  <= addr;
        awid    <= id[3:0];
        awlen   <= len[7:0];
        n = 0;
        @(negedge ACLK);
        while (!awready && n < TIMEOUT) begin
            n++;
            @(negedge ACLK);
        end
        if (!awready) report_timeout("awready");
        @(posedge ACLK);
        awvalid <= 1'b0;
        for (beat_no = 0; beat_no <= len; beat_no++) begin
            gap = stall ? int'(take_bits(2)) : 0;
            wvalid <= 1'b0;
            repeat (gap) @(posedge ACLK);
            wvalid <= 1'b1;
            wdata  <= take_bits(32);
            wlast  <= (beat_no == len);
            n = 0;
            @(negedge ACLK);
            // wready drops while the bank serves reads
            while (!wready && n < TIMEOUT) begin
                n++;
                @(negedge ACLK);
            end
            if (!wready) report_timeout("wready");
            @(posedge ACLK);
        end
        wvalid <= 1'b0;
        wlast  <= 1'b0;
    endtask

    // Wait for B, keep bready low for a while, then accept
    task automatic collect_b(input int hold);
        int n;
        bready <= 1'b0;
        n = 0;
        @(negedge ACLK);
        while (!bvalid && n < TIMEOUT) begin
            n++;
            @(negedge ACLK);
        end
        if (!bvalid) report_timeout("bvalid");
        @(posedge ACLK);
        repeat (hold) @(posedge ACLK);
        bready <= 1'b1;
        @(posedge ACLK);
        bready <= 1'b0;
    endtask

    task automatic read_burst(input logic [31:0] addr, input int id, input int len);
        int n;
        arvalid <= 1'b1;
        araddr  <= addr;
        arid    <= id[3:0];
        arlen   <= len[7:0];
        n = 0;
        @(negedge ACLK);
        while (!arready && n < TIMEOUT) begin
            n++;
            @(negedge ACLK);
        end
        if (!arready) report_timeout("arready");
        @(posedge ACLK);
        arvalid <= 1'b0;
    endtask

    // Count R handshakes, rready toggled at random when stall is set
    task automatic collect_r(input int nbeats, input bit stall);
        int got;
        int n;
        got = 0;
        n = 0;
        while (got < nbeats && n < TIMEOUT) begin
            rready <= stall ? (take_bits(1) != 0) : 1'b1;
            @(negedge ACLK);
            if (rvalid && rready) got++;
            n++;
            @(posedge ACLK);
        end
        rready <= 1'b0;
        if (got < nbeats) report_timeout("read beats");
    endtask

    // ==============================
    // Reference model
    // ==============================
    // Handshakes are seen mid-cycle and complete on the next rising edge
    always @(negedge ACLK) begin
        if (ARESETn) begin
            if (awvalid && awready) begin
                // Byte address to word address, upper bits wrap
                wr_word = awaddr[11:2];
                exp_bid = awid;
            end
            if (wvalid && wready) begin
                ref_mem[wr_word] = wdata;
                wr_word = wr_word + 1'b1;
                if (wlast) b_pending = 1'b1;
            end
            if (bvalid && bready) b_pending = 1'b0;
            if (rvalid && rready && exp_q.size() != 0) exp_q.delete(0);
            // Expected beats come from the reference array at AR time
            if (arvalid && arready) begin
                rd_word = araddr[11:2];
                for (mon_i = 0; mon_i <= int'(arlen); mon_i++) begin
                    mon_beat.data = ref_mem[rd_word];
                    mon_beat.id   = arid;
                    mon_beat.last = (mon_i == int'(arlen));
                    exp_q.push_back(mon_beat);
                    rd_word = rd_word + 1'b1;
                end
            end
        end
    end

    always @(posedge ACLK) begin
        exp_cnt <= exp_q.size();
        if (exp_q.size() != 0) begin
            exp_data <= exp_q[0].data;
            exp_id   <= exp_q[0].id;
            exp_last <= exp_q[0].last;
        end
    end

    // ==============================
    // Assertions
    // ==============================
    reset_state: assert property (@(negedge ACLK) disable iff (!ARESETn)
        reset_chk |-> (!bvalid && !rvalid && !wready && awready && arready))
    else begin
        proto_errs++;
        $display("Outputs not in their reset state after reset in test %s", test_name);
    end

    b_after_wlast: assert property (@(negedge ACLK) disable iff (!ARESETn)
        (wvalid && wready && wlast) |=> bvalid)
    else begin
        proto_errs++;
        $display("bvalid did not rise after the last write beat in test %s", test_name);
    end

    b_hold: assert property (@(negedge ACLK) disable iff (!ARESETn)
        (bvalid && !bready) |=> bvalid)
    else begin
        proto_errs++;
        $display("bvalid dropped before bready in test %s", test_name);
    end

    // No new write burst while a response waits
    b_blocks_aw: assert property (@(negedge ACLK) disable iff (!ARESETn)
        bvalid |-> !awready)
    else begin
        proto_errs++;
        $display("awready high while bvalid waits in test %s", test_name);
    end

    b_expected: assert property (@(negedge ACLK) disable iff (!ARESETn)
        (bvalid && bready) |-> b_pending)
    else begin
        proto_errs++;
        $display("Write response with no write burst outstanding in test %s", test_name);
    end

    b_fields: assert property (@(negedge ACLK) disable iff (!ARESETn)
        (bvalid && bready) |-> ({bid, bresp} == {exp_bid, axi_sram_pkg::RESP_OKAY}))
    else begin
        data_errs++;
        $display("Error %s: bid/bresp expected %h/%h actual %h/%h", test_name,
                 exp_bid, axi_sram_pkg::RESP_OKAY, bid, bresp);
    end

    r_expected: assert property (@(negedge ACLK) disable iff (!ARESETn)
        (rvalid && rready) |-> (exp_cnt != 0))
    else begin
        proto_errs++;
        $display("Read beat with no read outstanding in test %s", test_name);
    end

    r_data: assert property (@(negedge ACLK) disable iff (!ARESETn)
        (rvalid && rready && exp_cnt != 0) |-> (rdata == exp_data))
    else begin
        data_errs++;
        $display("Error %s: rdata expected %h actual %h", test_name, exp_data, rdata);
    end

    r_fields: assert property (@(negedge ACLK) disable iff (!ARESETn)
        (rvalid && rready && exp_cnt != 0) |->
        ({rid, rlast, rresp} == {exp_id, exp_last, axi_sram_pkg::RESP_OKAY}))
    else begin
        data_errs++;
        $display("Error %s: rid/rlast/rresp expected %h/%b/%h actual %h/%b/%h", test_name,
                 exp_id, exp_last, axi_sram_pkg::RESP_OKAY, rid, rlast, rresp);
    end

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        ARESETn   = 1'b0;
        awvalid   = 1'b0;
        awaddr    = '0;
        awid      = '0;
        awlen     = '0;
        wvalid    = 1'b0;
        wdata     = '0;
        wlast     = 1'b0;
        bready    = 1'b0;
        arvalid   = 1'b0;
        araddr    = '0;
        arid      = '0;
        arlen     = '0;
        rready    = 1'b0;
        reset_chk = 1'b0;
        b_pending = 1'b0;
        exp_cnt   = 0;
        test_name = "reset";
        repeat (2) @(posedge ACLK);
        ARESETn <= 1'b1;
        @(posedge ACLK);
        reset_chk <= 1'b1;
        @(posedge ACLK);
        reset_chk <= 1'b0;

        test_name = "write_then_read";
        write_burst(32'h100, 3, 7, 1'b0);
        collect_b(0);
        read_burst(32'h100, 5, 7);
        collect_r(8, 1'b0);

        // Random lengths, bready held low for a random time
        test_name = "b_backpressure";
        for (k = 0; k < 3; k++) begin
            lens[k] = take_bits(3);
            write_burst(32'h200 + k * 64, k + 1, lens[k], 1'b1);
            collect_b(int'(take_bits(3)) + 1);
        end

        // Back to back reads fill the queue while rready toggles
        test_name = "r_backpressure";
        fork
            begin
                read_burst(32'h200, 8, lens[0]);
                read_burst(32'h240, 9, lens[1]);
                read_burst(32'h280, 10, lens[2]);
            end
            collect_r(lens[0] + lens[1] + lens[2] + 3, 1'b1);
        join

        test_name = "concurrent";
        fork
            begin
                write_burst(32'h400, 2, 15, 1'b1);
                collect_b(1);
            end
            begin
                read_burst(32'h100, 6, 7);
                read_burst(32'h200, 7, lens[0]);
            end
            collect_r(lens[0] + 9, 1'b1);
        join
        read_burst(32'h400, 11, 15);
        collect_r(16, 1'b1);

        // Words 1020 to 1023 then 0 to 3
        test_name = "wrap";
        write_burst(32'h0000_0FF0, 12, 7, 1'b1);
        collect_b(0);
        read_burst(32'h0000_0FF0, 13, 7);
        collect_r(8, 1'b1);
        read_burst(32'h0000_1FF8, 14, 5);
        collect_r(6, 1'b1);

        test_name = "drain";
        repeat (10) @(posedge ACLK);
        assert (exp_q.size() == 0) else begin
            proto_errs++;
            $display("%0d expected read beats were never returned", exp_q.size());
        end
        assert (!b_pending) else begin
            proto_errs++;
            $display("A write burst never got its response");
        end

        $display("Errors: %0d data, %0d protocol, %0d timeout", data_errs, proto_errs, timeouts);
        if (data_errs + proto_errs + timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
